// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // Fetch starts from boot_addr_i, PC regs idle at zero until then
  localparam logic [XLEN-1:0] PC_RESET = 32'h0000_0000;
  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

  // Whole word accesses only
  localparam logic [XLEN/8-1:0] BE_ALL = 4'b1111;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_EQ,
    ALU_NE
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_RS1,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic [1:0] {
    OP_B_RS2,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_LSU,
    WB_PC4
  } wb_sel_e;

  // Decoded control bundle
  typedef struct packed {
    alu_op_e                 alu_op;
    op_a_sel_e               op_a_sel;
    op_b_sel_e               op_b_sel;
    wb_sel_e                 wb_sel;
    logic [XLEN-1:0]         imm;
    logic [REG_ADDR_W-1:0]   rs1;
    logic [REG_ADDR_W-1:0]   rs2;
    logic [REG_ADDR_W-1:0]   rd;
    logic                    is_load;
    logic                    is_store;
    logic                    is_branch;
    logic                    is_jal;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== src/core_ifs.sv ====
`timescale 1ns/1ns
`default_nettype none

// Fetched instruction from fetch to decode/execute, plus redirect back
interface fetch_id_if import core_pkg::*; ();
  logic            instr_valid;
  logic [XLEN-1:0] instr_rdata;
  logic [XLEN-1:0] instr_pc;
  logic            instr_ready;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;

  modport source (
    output instr_valid, instr_rdata, instr_pc,
    input  instr_ready, redirect, redirect_pc
  );

  modport sink (
    input  instr_valid, instr_rdata, instr_pc,
    output instr_ready, redirect, redirect_pc
  );
endinterface

// Memory requests from decode/execute to the LSU
interface lsu_req_if import core_pkg::*; ();
  logic            req_valid;
  logic            req_we;
  logic [XLEN-1:0] req_addr;
  logic [XLEN-1:0] req_wdata;
  logic            req_ready;
  logic            resp_valid;
  logic [XLEN-1:0] resp_rdata;

  modport master (
    output req_valid, req_we, req_addr, req_wdata,
    input  req_ready, resp_valid, resp_rdata
  );

  modport slave (
    input  req_valid, req_we, req_addr, req_wdata,
    output req_ready, resp_valid, resp_rdata
  );
endinterface

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu import core_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_o
);

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            lt;
  logic            eq;

  assign sum  = a_i + b_i;
  assign diff = a_i - b_i;
  assign lt   = $signed(a_i) < $signed(b_i);
  assign eq   = (a_i == b_i);

  always_comb begin
    case (op_i)
      ALU_SUB: result_o = diff;
      ALU_AND: result_o = a_i & b_i;
      ALU_OR:  result_o = a_i | b_i;
      ALU_XOR: result_o = a_i ^ b_i;
      ALU_SLT: result_o = {{(XLEN-1){1'b0}}, lt};
      // ADD, and the branch ops which only need cmp_o
      default: result_o = sum;
    endcase
  end

  // Branch condition
  assign cmp_o = (op_i == ALU_NE) ? ~eq : eq;

endmodule

`default_nettype wire

// ==== src/decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module decoder import core_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output ctrl_t           ctrl_o
);

  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    // Anything unmatched falls through as a no-op
    ctrl_o           = '0;
    ctrl_o.alu_op    = ALU_ADD;
    ctrl_o.op_a_sel  = OP_A_RS1;
    ctrl_o.op_b_sel  = OP_B_IMM;
    ctrl_o.wb_sel    = WB_NONE;
    ctrl_o.rs1       = instr_i[19:15];
    ctrl_o.rs2       = instr_i[24:20];
    ctrl_o.rd        = instr_i[11:7];

    case (opcode_e'(instr_i[6:0]))
      OPC_LUI: begin
        ctrl_o.op_a_sel = OP_A_ZERO;
        ctrl_o.imm      = imm_u;
        ctrl_o.wb_sel   = WB_ALU;
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          ctrl_o.imm    = imm_i;
          ctrl_o.wb_sel = WB_ALU;
        end
      end
      OPC_OP: begin
        ctrl_o.op_b_sel = OP_B_RS2;
        ctrl_o.wb_sel   = WB_ALU;
        case ({funct7, funct3})
          10'b0000000_000: ctrl_o.alu_op = ALU_ADD;
          10'b0100000_000: ctrl_o.alu_op = ALU_SUB;
          10'b0000000_111: ctrl_o.alu_op = ALU_AND;
          10'b0000000_110: ctrl_o.alu_op = ALU_OR;
          10'b0000000_100: ctrl_o.alu_op = ALU_XOR;
          10'b0000000_010: ctrl_o.alu_op = ALU_SLT;
          default:         ctrl_o.wb_sel = WB_NONE;
        endcase
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          ctrl_o.imm     = imm_i;
          ctrl_o.is_load = 1'b1;
          ctrl_o.wb_sel  = WB_LSU;
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          ctrl_o.imm      = imm_s;
          ctrl_o.is_store = 1'b1;
        end
      end
      OPC_BRANCH: begin
        ctrl_o.op_b_sel = OP_B_RS2;
        ctrl_o.imm      = imm_b;
        if (funct3 == 3'b000) begin
          ctrl_o.alu_op    = ALU_EQ;
          ctrl_o.is_branch = 1'b1;
        end else if (funct3 == 3'b001) begin
          ctrl_o.alu_op    = ALU_NE;
          ctrl_o.is_branch = 1'b1;
        end
      end
      OPC_JAL: begin
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.imm      = imm_j;
        ctrl_o.wb_sel   = WB_PC4;
        ctrl_o.is_jal   = 1'b1;
      end
      default: begin
        ctrl_o.wb_sel = WB_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/if_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module if_stage import core_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            fetch_enable_i,
  input  logic [XLEN-1:0] boot_addr_i,
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  fetch_id_if.source      fetch_if
);

  logic            started_q;
  logic            req_q;
  logic            pend_q;
  logic            buf_valid_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] next_pc_q;
  logic [XLEN-1:0] buf_rdata_q;
  logic [XLEN-1:0] buf_pc_q;
  logic            in_flight;
  logic            rsp_done;
  logic            consume;
  logic            slot_free;
  logic            issue;
  logic [XLEN-1:0] issue_addr;

  assign in_flight = req_q | pend_q;
  assign rsp_done  = pend_q & instr_rvalid_i;
  assign consume   = buf_valid_q & fetch_if.instr_ready;
  // Buffer is empty next cycle, or flushed by a redirect
  assign slot_free = ~buf_valid_q | consume | fetch_if.redirect;
  assign issue     = (started_q | fetch_enable_i) & ~in_flight & slot_free;

  assign issue_addr = fetch_if.redirect ? fetch_if.redirect_pc :
                      started_q         ? next_pc_q            : boot_addr_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q   <= 1'b0;
      req_q       <= 1'b0;
      pend_q      <= 1'b0;
      buf_valid_q <= 1'b0;
      addr_q      <= PC_RESET;
      next_pc_q   <= PC_RESET;
    end else begin
      if (fetch_enable_i) begin
        started_q <= 1'b1;
      end
      if (issue) begin
        req_q     <= 1'b1;
        addr_q    <= issue_addr;
        next_pc_q <= issue_addr + PC_STEP;
      end else if (fetch_if.redirect) begin
        next_pc_q <= fetch_if.redirect_pc;
      end
      if (req_q && instr_gnt_i) begin
        req_q  <= 1'b0;
        pend_q <= 1'b1;
      end
      if (rsp_done) begin
        pend_q <= 1'b0;
      end
      if (consume || fetch_if.redirect) begin
        buf_valid_q <= 1'b0;
      end
      if (rsp_done && !fetch_if.redirect) begin
        buf_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_done) begin
      buf_rdata_q <= instr_rdata_i;
      buf_pc_q    <= addr_q;
    end
  end

  assign instr_req_o          = req_q;
  assign instr_addr_o         = addr_q;
  assign fetch_if.instr_valid = buf_valid_q;
  assign fetch_if.instr_rdata = buf_rdata_q;
  assign fetch_if.instr_pc    = buf_pc_q;

  // Address held until the bus grants
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

`default_nettype wire

// ==== src/id_ex_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_ex_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  fetch_id_if.sink  fetch_if,
  lsu_req_if.master lsu_if
);

  typedef enum logic {
    IDLE,
    WAIT_MEM
  } state_e;

  state_e          state_q;
  state_e          state_d;
  ctrl_t           ctrl;
  logic [XLEN-1:0] rf_q [NUM_REGS];
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] br_tgt;
  logic [XLEN-1:0] wb_data;
  logic            alu_cmp;
  logic            is_mem;
  logic            exec;
  logic            rf_we;

  decoder u_decoder (
    .instr_i (fetch_if.instr_rdata),
    .ctrl_o  (ctrl)
  );

  // x0 reads as zero
  assign rs1_val = (ctrl.rs1 == '0) ? '0 : rf_q[ctrl.rs1];
  assign rs2_val = (ctrl.rs2 == '0) ? '0 : rf_q[ctrl.rs2];

  always_comb begin
    case (ctrl.op_a_sel)
      OP_A_PC:   op_a = fetch_if.instr_pc;
      OP_A_ZERO: op_a = '0;
      default:   op_a = rs1_val;
    endcase
  end

  assign op_b = (ctrl.op_b_sel == OP_B_RS2) ? rs2_val : ctrl.imm;

  alu u_alu (
    .op_i     (ctrl.alu_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  //////////////////////////////////////////////////////////////////////
  // Issue control
  //////////////////////////////////////////////////////////////////////

  assign is_mem = ctrl.is_load | ctrl.is_store;
  assign exec   = fetch_if.instr_valid & (state_q == IDLE);

  // Branch compares rs1/rs2 in the ALU, so its target needs its own adder
  assign br_tgt = fetch_if.instr_pc + ctrl.imm;

  assign fetch_if.redirect    = exec & (ctrl.is_jal | (ctrl.is_branch & alu_cmp));
  assign fetch_if.redirect_pc = ctrl.is_jal ? alu_result : br_tgt;
  assign fetch_if.instr_ready = (state_q == IDLE) ? ~is_mem : lsu_if.resp_valid;

  assign lsu_if.req_valid = exec & is_mem;
  assign lsu_if.req_we    = ctrl.is_store;
  assign lsu_if.req_addr  = alu_result;
  assign lsu_if.req_wdata = rs2_val;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (lsu_if.req_valid && lsu_if.req_ready) begin
          state_d = WAIT_MEM;
        end
      end
      WAIT_MEM: begin
        if (lsu_if.resp_valid) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write-back
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl.wb_sel)
      WB_LSU:  wb_data = lsu_if.resp_rdata;
      WB_PC4:  wb_data = fetch_if.instr_pc + PC_STEP;
      default: wb_data = alu_result;
    endcase
  end

  assign rf_we = (exec & ~is_mem & (ctrl.wb_sel != WB_NONE)) |
                 ((state_q == WAIT_MEM) & lsu_if.resp_valid & (ctrl.wb_sel == WB_LSU));

  always_ff @(posedge clk) begin
    if (rf_we && (ctrl.rd != '0)) begin
      rf_q[ctrl.rd] <= wb_data;
    end
  end

  // Flow change and memory access never issue together
  a_no_redirect_mem: assert property (@(posedge clk) disable iff (!rst_ni)
    !(fetch_if.redirect && lsu_if.req_valid));

endmodule

`default_nettype wire

// ==== src/load_store_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_store_unit import core_pkg::*; (
  input  logic              clk,
  input  logic              rst_ni,
  lsu_req_if.slave          lsu_if,
  output logic              data_req_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  output logic              data_we_o,
  output logic [XLEN/8-1:0] data_be_o,
  output logic [XLEN-1:0]   data_addr_o,
  output logic [XLEN-1:0]   data_wdata_o,
  input  logic [XLEN-1:0]   data_rdata_i
);

  logic            req_q;
  logic            pend_q;
  logic            resp_q;
  logic            we_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;
  logic [XLEN-1:0] rdata_q;
  logic            accept;

  // One access at a time
  assign lsu_if.req_ready = ~req_q & ~pend_q;
  assign accept           = lsu_if.req_valid & lsu_if.req_ready;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      pend_q <= 1'b0;
      resp_q <= 1'b0;
      we_q   <= 1'b0;
    end else begin
      resp_q <= pend_q & data_rvalid_i;
      if (accept) begin
        req_q <= 1'b1;
        we_q  <= lsu_if.req_we;
      end
      if (req_q && data_gnt_i) begin
        req_q  <= 1'b0;
        pend_q <= 1'b1;
      end
      if (pend_q && data_rvalid_i) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= lsu_if.req_addr;
      wdata_q <= lsu_if.req_wdata;
    end
    // Store responses carry no data, the capture is harmless
    if (pend_q && data_rvalid_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o        = req_q;
  assign data_we_o         = we_q;
  assign data_be_o         = BE_ALL;
  assign data_addr_o       = addr_q;
  assign data_wdata_o      = wdata_q;
  assign lsu_if.resp_valid = resp_q;
  assign lsu_if.resp_rdata = rdata_q;

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o));

endmodule

`default_nettype wire

// ==== src/core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_top import core_pkg::*; (
  input  logic              clk,
  input  logic              rst_ni,
  input  logic              fetch_enable_i,
  input  logic [XLEN-1:0]   boot_addr_i,

  // Instruction bus
  output logic              instr_req_o,
  output logic [XLEN-1:0]   instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  logic [XLEN-1:0]   instr_rdata_i,

  // Data bus
  output logic              data_req_o,
  output logic              data_we_o,
  output logic [XLEN/8-1:0] data_be_o,
  output logic [XLEN-1:0]   data_addr_o,
  output logic [XLEN-1:0]   data_wdata_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic [XLEN-1:0]   data_rdata_i
);

  fetch_id_if u_fetch_if ();
  lsu_req_if  u_lsu_if ();

  if_stage u_if_stage (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .fetch_if       (u_fetch_if)
  );

  id_ex_stage u_id_ex_stage (
    .clk      (clk),
    .rst_ni   (rst_ni),
    .fetch_if (u_fetch_if),
    .lsu_if   (u_lsu_if)
  );

  load_store_unit u_lsu (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .lsu_if        (u_lsu_if),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i)
  );

endmodule

`default_nettype wire

// ==== test/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam int K_LUI = 0, K_ADDI = 1, K_ADD = 2, K_SUB = 3, K_AND = 4, K_OR = 5;
localparam int K_XOR = 6, K_SLT = 7, K_LW = 8, K_SW = 9, K_BEQ = 10, K_BNE = 11;
localparam int K_JAL = 12;

int          kind   [PROG_LEN];
logic [4:0]  f_rd   [PROG_LEN];
logic [4:0]  f_rs1  [PROG_LEN];
logic [4:0]  f_rs2  [PROG_LEN];
logic [31:0] f_imm  [PROG_LEN];
logic [31:0] regs   [32];
logic [31:0] model_mem [DMEM_WORDS];
bit          exec_mark [IMEM_WORDS];
bit          wrong_ok  [IMEM_WORDS];
logic [31:0] exp_addr_q [$];
logic [31:0] exp_data_q [$];
int          halt_idx;

function automatic logic [31:0] encode(int k, logic [4:0] rd, logic [4:0] rs1,
                                       logic [4:0] rs2, logic [31:0] imm);
  case (k)
    K_LUI:  return {imm[31:12], rd, 7'b0110111};
    K_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    K_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    K_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
    K_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
    K_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
    K_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
    K_SLT:  return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
    K_LW:   return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    K_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    K_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
    K_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    default: return 32'h0;
  endcase
endfunction

task automatic put_instr(int idx, int k, int rd, int rs1, int rs2, logic [31:0] imm);
  kind[idx]  = k;
  f_rd[idx]  = rd[4:0];
  f_rs1[idx] = rs1[4:0];
  f_rs2[idx] = rs2[4:0];
  f_imm[idx] = imm;
endtask

// Prologue sets up x30 as data base and every other register, body is random,
// then x31 points at the dump area and x1..x31 are stored
task automatic build_program();
  logic [31:0] r;
  int          k;
  int          off;
  int          rs1;
  int          rs2;
  int          dump_idx;
  dump_idx = 30 + BODY_LEN;
  put_instr(0, K_LUI, 30, 0, 0, DATA_BASE);
  for (int i = 1; i < 30; i++) begin
    r = $random(seed);
    put_instr(i, K_ADDI, i, 0, 0, {{20{r[11]}}, r[11:0]});
  end
  for (int i = 30; i < dump_idx; i++) begin
    k   = {$random(seed)} % 13;
    r   = $random(seed);
    rs1 = {$random(seed)} % 31;
    rs2 = {$random(seed)} % 31;
    off = 1 + {$random(seed)} % 3;
    if (i + off > dump_idx) begin
      off = dump_idx - i;
    end
    case (k)
      K_LUI: put_instr(i, k, 1 + {$random(seed)} % 29, 0, 0, {r[31:12], 12'b0});
      K_LW, K_SW: put_instr(i, k, 1 + {$random(seed)} % 29, 30, rs2,
                            4 * ({$random(seed)} % DMEM_WORDS));
      K_BEQ, K_BNE: put_instr(i, k, 0, rs1, r[0] ? rs1 : rs2, 4 * off);
      K_JAL: put_instr(i, k, 1 + {$random(seed)} % 29, 0, 0, 4 * off);
      default: put_instr(i, k, 1 + {$random(seed)} % 29, rs1, rs2, {{20{r[11]}}, r[11:0]});
    endcase
  end
  put_instr(dump_idx, K_LUI, 31, 0, 0, DUMP_BASE);
  for (int i = 1; i < 32; i++) begin
    put_instr(dump_idx + i, K_SW, 0, 31, i, 4 * i);
  end
  put_instr(PROG_LEN - 1, K_JAL, 0, 0, 0, 32'h0);
endtask

task automatic write_reg(logic [4:0] rd, logic [31:0] val);
  if (rd != 0) begin
    regs[rd] = val;
  end
endtask

// Executes the program by the RV32I rules and records every store in order
task automatic run_model();
  int          pc;
  int          next;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] addr;
  bit          taken;
  pc = 0;
  foreach (regs[i]) regs[i] = 32'h0;
  foreach (model_mem[w]) model_mem[w] = fill_word(DATA_BASE + 4 * w);
  while (!(kind[pc] == K_JAL && f_imm[pc] == 0)) begin
    exec_mark[pc] = 1'b1;
    a     = regs[f_rs1[pc]];
    b     = regs[f_rs2[pc]];
    addr  = a + f_imm[pc];
    next  = pc + 1;
    taken = 1'b0;
    case (kind[pc])
      K_LUI:  write_reg(f_rd[pc], f_imm[pc]);
      K_ADDI: write_reg(f_rd[pc], a + f_imm[pc]);
      K_ADD:  write_reg(f_rd[pc], a + b);
      K_SUB:  write_reg(f_rd[pc], a - b);
      K_AND:  write_reg(f_rd[pc], a & b);
      K_OR:   write_reg(f_rd[pc], a | b);
      K_XOR:  write_reg(f_rd[pc], a ^ b);
      K_SLT:  write_reg(f_rd[pc], {31'b0, $signed(a) < $signed(b)});
      K_LW:   write_reg(f_rd[pc], model_mem[(addr - DATA_BASE) >> 2]);
      K_SW: begin
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(b);
        if (in_window(addr)) model_mem[(addr - DATA_BASE) >> 2] = b;
      end
      K_BEQ:  taken = (a == b);
      K_BNE:  taken = (a != b);
      K_JAL: begin
        write_reg(f_rd[pc], BOOT_ADDR + 4 * pc + 4);
        taken = 1'b1;
      end
      default: ;
    endcase
    if (taken) begin
      next = pc + int'(f_imm[pc] >> 2);
      // Prefetch past a taken flow change may show up on the bus
      wrong_ok[pc + 1] = 1'b1;
      wrong_ok[pc + 2] = 1'b1;
    end
    pc = next;
  end
  exec_mark[pc]     = 1'b1;
  wrong_ok[pc + 1]  = 1'b1;
  wrong_ok[pc + 2]  = 1'b1;
  halt_idx          = pc;
endtask

`endif

// ==== test/tb_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_core;

  localparam int          BODY_LEN   = 40;
  localparam int          PROG_LEN   = 30 + BODY_LEN + 33;
  localparam int          IMEM_WORDS = 128;
  localparam int          DMEM_WORDS = 64;
  localparam logic [31:0] BOOT_ADDR  = 32'h0000_0080;
  localparam logic [31:0] DATA_BASE  = 32'h0000_1000;
  localparam logic [31:0] DUMP_BASE  = 32'h0000_2000;
  localparam logic [31:0] FILL_KEY   = 32'h5a5a_0f0f;
  localparam int          LIMIT      = PROG_LEN * 20;

  logic        clk;
  logic        rst_ni;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic        data_req_o, data_we_o, data_gnt_i, data_rvalid_i;
  logic [3:0]  data_be_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;

  integer      seed = 32'h7f57_d326;
  int          errors = 0;
  int          cycles;
  bit          halt_seen = 1'b0;
  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];

  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return addr ^ FILL_KEY;
  endfunction

  function automatic bit in_window(logic [31:0] addr);
    return addr >= DATA_BASE && addr < DATA_BASE + 4 * DMEM_WORDS;
  endfunction

  `include "core_model.svh"

  core_top u_dut (.*);

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("error: %s expected %h got %h", name, exp, act);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // Instruction bus responder
  ////////////////////////////////////////////////////////////////////////

  initial begin : instr_bus
    int          wait_cnt;
    int          lat;
    int          idx;
    bit          seen;
    bit          first;
    logic [31:0] addr;
    lat   = 0;
    seen  = 1'b0;
    first = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      if (lat > 0) begin
        lat--;
        if (lat == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = imem[(addr - BOOT_ADDR) >> 2];
        end
      end else if (instr_req_o) begin
        if (seen) begin
          check_value("instr_addr_o", addr, instr_addr_o);
        end else begin
          seen     = 1'b1;
          addr     = instr_addr_o;
          wait_cnt = {$random(seed)} % 4;
          idx      = (addr - BOOT_ADDR) >> 2;
          if (first) check_value("instr_addr_o", BOOT_ADDR, addr);
          first = 1'b0;
          if (!fetch_enable_i) begin
            errors++;
            $display("Fetch request seen before fetch enable");
          end
          if (addr < BOOT_ADDR || addr[1:0] != 0 || idx >= IMEM_WORDS ||
              !(exec_mark[idx] || wrong_ok[idx])) begin
            errors++;
            $display("Fetch from %h lies off every path the program can take", addr);
            idx = 0;
          end
          if (idx == halt_idx) halt_seen = 1'b1;
        end
        if (wait_cnt == 0) begin
          instr_gnt_i = 1'b1;
          seen        = 1'b0;
          lat         = 1 + {$random(seed)} % 3;
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Data bus responder and store checks
  ////////////////////////////////////////////////////////////////////////

  initial begin : data_bus
    int          wait_cnt;
    int          lat;
    bit          seen;
    logic [31:0] addr;
    logic [31:0] rdata;
    lat  = 0;
    seen = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      data_gnt_i    = 1'b0;
      data_rvalid_i = 1'b0;
      if (lat > 0) begin
        lat--;
        if (lat == 0) begin
          data_rvalid_i = 1'b1;
          data_rdata_i  = rdata;
        end
      end else if (data_req_o) begin
        if (seen) begin
          check_value("data_addr_o", addr, data_addr_o);
        end else begin
          seen     = 1'b1;
          addr     = data_addr_o;
          wait_cnt = {$random(seed)} % 4;
        end
        if (wait_cnt == 0) begin
          data_gnt_i = 1'b1;
          seen       = 1'b0;
          lat        = 1 + {$random(seed)} % 3;
          check_value("data_be_o", 32'hf, {28'h0, data_be_o});
          rdata = in_window(addr) ? dmem[(addr - DATA_BASE) >> 2] : fill_word(addr);
          if (data_we_o) begin
            if (exp_addr_q.size() == 0) begin
              errors++;
              $display("Store to %h comes after the last expected store", addr);
            end else begin
              check_value("data_addr_o", exp_addr_q.pop_front(), addr);
              check_value("data_wdata_o", exp_data_q.pop_front(), data_wdata_o);
            end
            if (in_window(addr)) dmem[(addr - DATA_BASE) >> 2] = data_wdata_o;
          end
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Stimulus and end of run
  ////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = 32'h0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = 32'h0;
    build_program();
    run_model();
    foreach (imem[i]) imem[i] = (i < PROG_LEN) ?
      encode(kind[i], f_rd[i], f_rs1[i], f_rs2[i], f_imm[i]) : 32'h0;
    foreach (dmem[w]) dmem[w] = fill_word(DATA_BASE + 4 * w);
    // Bus stays quiet through reset
    repeat (16) begin
      @(posedge clk);
      check_value("instr_req_o", 32'h0, {31'h0, instr_req_o});
      check_value("data_req_o", 32'h0, {31'h0, data_req_o});
      check_value("data_we_o", 32'h0, {31'h0, data_we_o});
    end
    #1 rst_ni = 1'b1;
    repeat (3) @(posedge clk);
    #1 fetch_enable_i = 1'b1;
    cycles = 0;
    while (!(halt_seen && exp_addr_q.size() == 0)) begin
      @(posedge clk);
      cycles++;
      if (cycles > LIMIT) begin
        errors++;
        $display("Timeout after %0d cycles, the core never reached its self-jump", cycles);
        break;
      end
    end
    repeat (8) @(posedge clk);
    $display("Run finished with %0d errors, %0d stores left unmatched",
             errors, exp_addr_q.size());
    if (errors == 0 && exp_addr_q.size() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+test
src/core_pkg.sv
src/core_ifs.sv
src/alu.sv
src/decoder.sv
src/if_stage.sv
src/id_ex_stage.sv
src/load_store_unit.sv
src/core_top.sv
test/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
